// ==== rtl/cam_pkg.sv ====
/* shared widths, reset values and encodings of the capture path
   FIFO depth must stay a power of two, the pointers wrap freely */
package cam_pkg;

	// ====================
	// widths
	localparam int pix_w       = 12;  // sensor sample
	localparam int x_w         = 11;  // column counter
	localparam int y_w         = 11;  // row counter
	localparam int word_w      = 32;  // packed bw word, also the bus width
	localparam int frame_cnt_w = 16;

	// image FIFO
	localparam int fifo_depth = 4;
	localparam int lvl_w      = 3;  // holds 0..fifo_depth

	// threshold out of reset, mid scale
	localparam logic [pix_w-1:0] thresh_reset = 12'h800;

	// ====================
	// host register map, word addresses
	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,  // bit0 cap_en, bit1 write 1 clears overflow
		REG_THRESH = 2'd1,  // 12 bit threshold
		REG_STATUS = 2'd2,  // level, overflow, frame count
		REG_IMG    = 2'd3   // read pops one word
	} reg_addr_e;

	// capture control
	typedef enum logic [1:0] {
		CAP_IDLE   = 2'd0,  // disabled
		CAP_ARMED  = 2'd1,  // waiting for next frame start
		CAP_ACTIVE = 2'd2   // frame in progress
	} cap_state_e;

endpackage

// ==== rtl/cam_pix_if.sv ====
/* pixel stream from capture to conversion, no back-pressure
   x and y are only meaningful while valid is high */
interface cam_pix_if
	import cam_pkg::*;
();

	logic [pix_w-1:0] data;       // raw sample
	logic             valid;      // one cycle per active pixel
	logic [x_w-1:0]   x;          // column of this pixel
	logic [y_w-1:0]   y;          // row of this pixel
	logic             frame_end;  // pulse after last line of a captured frame

	// capture side
	modport src (
		output data, valid, x, y, frame_end
	);

	// conversion side
	modport dst (
		input data, valid, x, y, frame_end
	);

endinterface

// ==== rtl/ccd_capture.sv ====
/* sensor pins are taken as synchronous to CCD_PIXCLK, no synchronizer
   capture starts at the first fval rise after cap_en is set and stops at
   the end of the frame in progress once cap_en is cleared */
module ccd_capture
	import cam_pkg::*;
(
	input  logic                   CCD_PIXCLK,
	input  logic                   rst_n,
	input  logic [pix_w-1:0]       ccd_data,
	input  logic                   ccd_fval,
	input  logic                   ccd_lval,
	input  logic                   cap_en,
	cam_pix_if.src                 pix,
	output logic [frame_cnt_w-1:0] frame_cnt
);

	logic [pix_w-1:0] data_r;          // pin register
	logic             fval_r, lval_r;  // pin register
	logic             fval_d, lval_d;  // previous cycle for edge detect
	logic             fval_rise, fval_fall, lval_fall;
	logic             capturing;       // frame accepted this cycle
	logic             emit;            // pixel goes out next edge
	cap_state_e       state;
	logic [x_w-1:0]   x_cnt;
	logic [y_w-1:0]   y_cnt;

	// ====================
	// pin stage
	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fval_r <= 1'b0;
			lval_r <= 1'b0;
			fval_d <= 1'b0;
			lval_d <= 1'b0;
		end
		else
		begin
			fval_r <= ccd_fval;
			lval_r <= ccd_lval;
			fval_d <= fval_r;
			lval_d <= lval_r;
		end
	end

	assign fval_rise = fval_r & ~fval_d;
	assign fval_fall = ~fval_r & fval_d;
	assign lval_fall = ~lval_r & lval_d;

	// line valid may rise together with frame valid, so the rise cycle counts too
	assign capturing = (state == CAP_ACTIVE) || (state == CAP_ARMED && cap_en && fval_rise);
	assign emit      = capturing & fval_r & lval_r;

	// ====================
	// start / stop FSM
	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= CAP_IDLE;
			frame_cnt <= '0;
		end
		else
		begin
			case (state)
				CAP_IDLE:
					if (cap_en)
						state <= CAP_ARMED;
				CAP_ARMED:
					if (!cap_en)
						state <= CAP_IDLE;
					else if (fval_rise)
						state <= CAP_ACTIVE;  // enabled mid frame waits here for the next one
				CAP_ACTIVE:
					if (fval_fall)
					begin
						state     <= cap_en ? CAP_ARMED : CAP_IDLE;
						frame_cnt <= frame_cnt + 1'b1;  // completed frames only
					end
				default:
					state <= CAP_IDLE;
			endcase
		end
	end

	// ====================
	// counters and stream control
	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			x_cnt         <= '0;
			y_cnt         <= '0;
			pix.valid     <= 1'b0;
			pix.frame_end <= 1'b0;
		end
		else
		begin
			pix.valid     <= emit;
			pix.frame_end <= (state == CAP_ACTIVE) && fval_fall;
			if (!lval_r)
				x_cnt <= '0;  // new line starts at column 0
			else if (emit)
				x_cnt <= x_cnt + 1'b1;
			if (!fval_r)
				y_cnt <= '0;  // row 0 until the frame starts
			else if (capturing && lval_fall)
				y_cnt <= y_cnt + 1'b1;  // next row at each line end
		end
	end

	// stream payload
	always_ff @(posedge CCD_PIXCLK)
	begin
		data_r <= ccd_data;
		if (emit)
		begin
			pix.data <= data_r;
			pix.x    <= x_cnt;
			pix.y    <= y_cnt;
		end
	end

endmodule

// ==== rtl/raw2bw.sv ====
/* keeps the top-left pixel of each 2x2 quad, i.e. even x and even y,
   and turns it into one bit, 1 when at or above threshold */
module raw2bw
	import cam_pkg::*;
(
	input  logic             CCD_PIXCLK,
	input  logic             rst_n,
	cam_pix_if.dst           pix,
	input  logic [pix_w-1:0] threshold,
	output logic             bw,
	output logic             bw_valid,
	output logic             frame_end
);

	logic keep;  // pixel survives decimation

	assign keep = pix.valid & ~pix.x[0] & ~pix.y[0];

	// ====================
	// strobes, one stage
	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bw_valid  <= 1'b0;
			frame_end <= 1'b0;
		end
		else
		begin
			bw_valid  <= keep;
			frame_end <= pix.frame_end;  // same delay as the bits, stays behind the last one
		end
	end

	// threshold compare, unsigned
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (keep)
			bw <= (pix.data >= threshold);
	end

endmodule

// ==== rtl/bit_queuer.sv ====
/* packs bits LSB first into words, pads a partial word with zeros at frame end
   bw_valid and frame_end never arrive in the same cycle
   a word pushed into a full FIFO is lost and sets the sticky overflow flag */
module bit_queuer
	import cam_pkg::*;
(
	input  logic              CCD_PIXCLK,
	input  logic              rst_n,
	input  logic              bw,
	input  logic              bw_valid,
	input  logic              frame_end,
	input  logic              pop,
	input  logic              ovf_clr,
	output logic [word_w-1:0] fifo_word,
	output logic [lvl_w-1:0]  level,
	output logic              overflow
);

	logic [word_w-1:0]             sh;         // newest bit enters at the top
	logic [$clog2(word_w)-1:0]     bit_cnt;    // bits held in sh
	logic                          word_done;  // 32nd bit arriving
	logic                          flush;      // frame end with bits pending
	logic                          push, push_ok, pop_ok, full;
	logic [word_w-1:0]             push_word;
	logic [word_w-1:0]             mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr, rd_ptr;

	// ====================
	// packer
	assign word_done = bw_valid && (bit_cnt == '1);
	assign flush     = frame_end && (bit_cnt != '0);
	assign push      = word_done | flush;

	// partial word sits at the top of sh, shift it down so zeros fill the top
	assign push_word = word_done ? {bw, sh[word_w-1:1]} : (sh >> (word_w - int'(bit_cnt)));

	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (bw_valid)
			bit_cnt <= bit_cnt + 1'b1;  // wraps to 0 on a full word
		else if (frame_end)
			bit_cnt <= '0;  // next frame starts a fresh word
	end

	always_ff @(posedge CCD_PIXCLK)
	begin
		if (bw_valid)
			sh <= {bw, sh[word_w-1:1]};
	end

	// ====================
	// four word FIFO
	assign full    = (level == lvl_w'(fifo_depth));
	assign pop_ok  = pop && (level != '0);
	assign push_ok = push && (!full || pop_ok);  // full plus pop still has room

	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			level    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				level <= level + 1'b1;
			else if (pop_ok && !push_ok)
				level <= level - 1'b1;
			// set wins over clear in the same cycle
			if (push && !push_ok)
				overflow <= 1'b1;
			else if (ovf_clr)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge CCD_PIXCLK)
	begin
		if (push_ok)
			mem[wr_ptr] <= push_word;
	end

	assign fifo_word = mem[rd_ptr];  // head, valid when level != 0

endmodule

// ==== rtl/cam_regs.sv ====
/* Wishbone classic slave, ack one cycle after cyc & stb, every access two cycles
   reading REG_IMG on an empty FIFO returns 0 and pops nothing */
module cam_regs
	import cam_pkg::*;
(
	input  logic                   CCD_PIXCLK,
	input  logic                   rst_n,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [1:0]             wb_adr,
	input  logic [word_w-1:0]      wb_dat_i,
	output logic [word_w-1:0]      wb_dat_o,
	output logic                   wb_ack,
	input  logic [word_w-1:0]      fifo_word,
	input  logic [lvl_w-1:0]       level,
	input  logic                   overflow,
	input  logic [frame_cnt_w-1:0] frame_cnt,
	output logic                   cap_en,
	output logic [pix_w-1:0]       threshold,
	output logic                   pop,
	output logic                   ovf_clr
);

	reg_addr_e         addr;
	logic              acc;     // access accepted this cycle
	logic              wr_acc, rd_acc;
	logic [word_w-1:0] rd_data;

	assign addr   = reg_addr_e'(wb_adr);
	assign acc    = wb_cyc & wb_stb & ~wb_ack;  // ack low, so one ack per access
	assign wr_acc = acc & wb_we;
	assign rd_acc = acc & ~wb_we;

	// ====================
	// read mux
	always_comb
	begin
		case (addr)
			REG_CTRL:   rd_data = word_w'(cap_en);  // bit1 reads 0
			REG_THRESH: rd_data = word_w'(threshold);
			REG_STATUS: rd_data = {frame_cnt,
			                       {(word_w - frame_cnt_w - lvl_w - 1){1'b0}},
			                       overflow, level};
			REG_IMG:    rd_data = (level != '0) ? fifo_word : '0;
			default:    rd_data = '0;
		endcase
	end

	// ====================
	// ack, control regs, pulses
	always_ff @(posedge CCD_PIXCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_ack    <= 1'b0;
			cap_en    <= 1'b0;
			threshold <= thresh_reset;
			pop       <= 1'b0;
			ovf_clr   <= 1'b0;
		end
		else
		begin
			wb_ack  <= acc;
			// pop lands during the ack cycle, head already latched in wb_dat_o
			pop     <= rd_acc && (addr == REG_IMG) && (level != '0);
			ovf_clr <= wr_acc && (addr == REG_CTRL) && wb_dat_i[1];
			if (wr_acc)
			begin
				case (addr)
					REG_CTRL:   cap_en    <= wb_dat_i[0];
					REG_THRESH: threshold <= wb_dat_i[pix_w-1:0];
					default:    ;  // status and image are read only
				endcase
			end
		end
	end

	// read data held through the ack cycle
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (rd_acc)
			wb_dat_o <= rd_data;
	end

endmodule

// ==== rtl/cam_top.sv ====
/* capture path top, single clock domain on CCD_PIXCLK
   sensor pins go straight in, host sees a 4 word Wishbone classic slave */
module cam_top
	import cam_pkg::*;
(
	input  logic              CCD_PIXCLK,
	input  logic              rst_n,
	input  logic [pix_w-1:0]  ccd_data,
	input  logic              ccd_fval,
	input  logic              ccd_lval,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [1:0]        wb_adr,
	input  logic [word_w-1:0] wb_dat_i,
	output logic [word_w-1:0] wb_dat_o,
	output logic              wb_ack
);

	cam_pix_if pix_if ();  // capture to conversion

	logic                   cap_en;
	logic [pix_w-1:0]       threshold;
	logic [frame_cnt_w-1:0] frame_cnt;
	logic                   bw, bw_valid, bw_frame_end;  // conversion to queuer
	logic                   pop, ovf_clr;
	logic [word_w-1:0]      fifo_word;
	logic [lvl_w-1:0]       level;
	logic                   overflow;

	// ====================
	// datapath
	ccd_capture cap_i (
		.CCD_PIXCLK (CCD_PIXCLK),
		.rst_n      (rst_n),
		.ccd_data   (ccd_data),
		.ccd_fval   (ccd_fval),
		.ccd_lval   (ccd_lval),
		.cap_en     (cap_en),
		.pix        (pix_if.src),
		.frame_cnt  (frame_cnt)
	);

	raw2bw bw_i (
		.CCD_PIXCLK (CCD_PIXCLK),
		.rst_n      (rst_n),
		.pix        (pix_if.dst),
		.threshold  (threshold),
		.bw         (bw),
		.bw_valid   (bw_valid),
		.frame_end  (bw_frame_end)
	);

	bit_queuer queue_i (
		.CCD_PIXCLK (CCD_PIXCLK),
		.rst_n      (rst_n),
		.bw         (bw),
		.bw_valid   (bw_valid),
		.frame_end  (bw_frame_end),
		.pop        (pop),
		.ovf_clr    (ovf_clr),
		.fifo_word  (fifo_word),
		.level      (level),
		.overflow   (overflow)
	);

	// host port
	cam_regs regs_i (
		.CCD_PIXCLK (CCD_PIXCLK),
		.rst_n      (rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack),
		.fifo_word  (fifo_word),
		.level      (level),
		.overflow   (overflow),
		.frame_cnt  (frame_cnt),
		.cap_en     (cap_en),
		.threshold  (threshold),
		.pop        (pop),
		.ovf_clr    (ovf_clr)
	);

endmodule

// ==== tb/cam_chk.sv ====
/* host port and FIFO rules of cam_top, checked only out of reset
   level is the internal FIFO fill of the queuer */
module cam_chk
	import cam_pkg::*;
(
	input logic             CCD_PIXCLK,
	input logic             rst_n,
	input logic             wb_cyc,
	input logic             wb_stb,
	input logic             wb_ack,
	input logic [lvl_w-1:0] level
);

	// ====================
	// Wishbone classic
	ack_needs_req: assert property (@(posedge CCD_PIXCLK) disable iff (!rst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("ack rose without cyc and stb");

	// single cycle ack
	ack_one_cycle: assert property (@(posedge CCD_PIXCLK) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("ack held for two cycles");

	// ====================
	// image FIFO
	level_bound: assert property (@(posedge CCD_PIXCLK) disable iff (!rst_n)
		level <= lvl_w'(fifo_depth))
		else $error("FIFO level above depth");

endmodule

bind cam_top cam_chk chk_i (
	.CCD_PIXCLK (CCD_PIXCLK),
	.rst_n      (rst_n),
	.wb_cyc     (wb_cyc),
	.wb_stb     (wb_stb),
	.wb_ack     (wb_ack),
	.level      (level)
);

// ==== tb/cam_tb.sv ====
/* frames of LFSR pixels go through cam_top, words come back over Wishbone
   expected words are built by a model of the decimation, threshold and packing rules */
module cam_tb
	import cam_pkg::*;
();

	logic              CCD_PIXCLK;
	logic              rst_n;
	logic [pix_w-1:0]  ccd_data;
	logic              ccd_fval, ccd_lval;
	logic              wb_cyc, wb_stb, wb_we;
	logic [1:0]        wb_adr;
	logic [word_w-1:0] wb_dat_i;
	logic [word_w-1:0] wb_dat_o;
	logic              wb_ack;

	// ====================
	// frame table
	string            tbl_name  [4] = '{"decimate_pack", "frame_end_pad", "capture_off", "overflow"};
	int               tbl_w     [4] = '{16, 10, 16, 64};
	int               tbl_h     [4] = '{8, 6, 8, 12};
	logic [pix_w-1:0] tbl_thr   [4] = '{12'h800, 12'h400, 12'h600, 12'hA00};
	logic             tbl_en    [4] = '{1'b1, 1'b1, 1'b0, 1'b1};
	int               tbl_words [4] = '{1, 1, 0, 6};  // 15 kept bits in frame 1

	// reference model state
	logic [15:0]       lfsr;
	logic [word_w-1:0] exp_q [$];  // words in push order
	logic [word_w-1:0] pack_word;
	int                pack_n;     // bits in pack_word
	int                exp_frames;

	cam_top dut_i (.*);

	always #50 CCD_PIXCLK = ~CCD_PIXCLK;

	// ====================
	// helpers
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // taps 16,14,13,11
	endfunction

	// one LFSR step per pixel bit
	function automatic logic [pix_w-1:0] rand_pixel();
		logic [pix_w-1:0] p;
		for (int i = 0; i < pix_w; i++)
		begin
			p[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return p;
	endfunction

	function automatic logic [word_w-1:0] status_word(input int frames, input logic ovf,
	                                                   input int lvl);
		return {frames[15:0], 12'h000, ovf, lvl[2:0]};
	endfunction

	task automatic check_eq(input string name, input logic [word_w-1:0] exp,
	                        input logic [word_w-1:0] act);
		assert (act === exp)
		else
		begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	// ====================
	// Wishbone master
	task automatic wait_ack();
		int cycles;
		cycles = 0;
		@(negedge CCD_PIXCLK);
		while (!wb_ack)
		begin
			if (cycles == 16)
				abort_run("Wishbone slave gave no ack within 16 cycles");
			cycles++;
			@(negedge CCD_PIXCLK);
		end
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [word_w-1:0] data);
		@(posedge CCD_PIXCLK);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= adr;
		wb_dat_i <= data;
		wait_ack();
		@(posedge CCD_PIXCLK);
		wb_cyc <= 1'b0;  // ack seen so the cycle ends
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [word_w-1:0] data);
		@(posedge CCD_PIXCLK);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= adr;
		wait_ack();
		data = wb_dat_o;  // valid while ack high
		@(posedge CCD_PIXCLK);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	// poll status until it matches or the poll limit runs out
	task automatic wait_status(input string name, input logic [word_w-1:0] want);
		logic [word_w-1:0] got;
		int                polls;
		polls = 0;
		wb_read(REG_STATUS, got);
		while (got !== want && polls < 32)
		begin
			polls++;
			wb_read(REG_STATUS, got);
		end
		check_eq(name, want, got);
	endtask

	// ====================
	// reference model
	task automatic model_pixel(input int x, input int y, input logic [pix_w-1:0] p,
	                           input logic [pix_w-1:0] thr);
		if (x % 2 == 0 && y % 2 == 0)  // top-left of each quad
		begin
			pack_word[pack_n] = (p >= thr);  // LSB first
			pack_n++;
			if (pack_n == word_w)
			begin
				exp_q.push_back(pack_word);
				pack_word = '0;
				pack_n    = 0;
			end
		end
	endtask

	task automatic model_frame_end();
		if (pack_n != 0)
			exp_q.push_back(pack_word);  // upper bits already zero
		pack_word = '0;
		pack_n    = 0;
	endtask

	// drive one sensor frame with two blank cycles after each line
	task automatic drive_frame(input int f);
		logic [pix_w-1:0] p;
		pack_word = '0;
		pack_n    = 0;
		repeat (3) @(posedge CCD_PIXCLK);  // vertical blanking
		ccd_fval <= 1'b1;
		for (int y = 0; y < tbl_h[f]; y++)
		begin
			for (int x = 0; x < tbl_w[f]; x++)
			begin
				@(posedge CCD_PIXCLK);
				p = rand_pixel();
				ccd_lval <= 1'b1;
				ccd_data <= p;
				if (tbl_en[f])
					model_pixel(x, y, p, tbl_thr[f]);
			end
			@(posedge CCD_PIXCLK);
			ccd_lval <= 1'b0;
			@(posedge CCD_PIXCLK);  // horizontal blanking
		end
		@(posedge CCD_PIXCLK);
		ccd_fval <= 1'b0;
		if (tbl_en[f])
		begin
			model_frame_end();
			exp_frames++;
		end
		repeat (4) @(posedge CCD_PIXCLK);
	endtask

	// ====================
	// test sequence
	initial
	begin
		logic [word_w-1:0] rd;
		int                lvl;
		logic              ovf;
		CCD_PIXCLK = 1'b0;
		rst_n      = 1'b0;
		ccd_data   = '0;
		ccd_fval   = 1'b0;
		ccd_lval   = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_i   = '0;
		lfsr       = 16'd10081;
		exp_frames = 0;
		repeat (4) @(posedge CCD_PIXCLK);
		rst_n <= 1'b1;

		// reset values
		wb_read(REG_CTRL, rd);
		check_eq("reset ctrl", '0, rd);
		wb_read(REG_THRESH, rd);
		check_eq("reset thresh", word_w'(thresh_reset), rd);
		wb_read(REG_STATUS, rd);
		check_eq("reset status", status_word(0, 1'b0, 0), rd);

		for (int f = 0; f < $size(tbl_w); f++)
		begin
			wb_write(REG_THRESH, word_w'(tbl_thr[f]));
			wb_write(REG_CTRL, word_w'(tbl_en[f]));
			drive_frame(f);
			check_eq({tbl_name[f], " model words"}, word_w'(tbl_words[f]), word_w'(exp_q.size()));
			lvl = (exp_q.size() > fifo_depth) ? fifo_depth : exp_q.size();
			ovf = (exp_q.size() > fifo_depth);  // extra words are dropped
			wait_status({tbl_name[f], " status"}, status_word(exp_frames, ovf, lvl));
			for (int i = 0; i < lvl; i++)
			begin
				wb_read(REG_IMG, rd);
				check_eq({tbl_name[f], " word"}, exp_q[i], rd);
			end
			if (lvl == 0)
			begin
				wb_read(REG_IMG, rd);
				check_eq({tbl_name[f], " empty read"}, '0, rd);
			end
			if (ovf)
				wb_write(REG_CTRL, word_w'(tbl_en[f]) | 32'h2);  // clear overflow
			wb_read(REG_STATUS, rd);
			check_eq({tbl_name[f], " drained"}, status_word(exp_frames, 1'b0, 0), rd);
			exp_q.delete();
		end

		$display("test passed");
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/cam_pkg.sv
rtl/cam_pix_if.sv
rtl/ccd_capture.sv
rtl/raw2bw.sv
rtl/bit_queuer.sv
rtl/cam_regs.sv
rtl/cam_top.sv
tb/cam_chk.sv
tb/cam_tb.sv

// ==== Makefile ====
# Verilator build and run of the camera capture testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cam_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
